//--- corr_pkg.sv
// correlator sizes and types
// shared by the sampler, the engine and the transmitter
package corr_pkg;

	localparam int NUM_INPUTS = 4;
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int RESOLUTION = 16;
	localparam int TICK_CYCLES = 4;
	localparam int BAUD_CYCLES = 8;

	// totals, lag-one autocorrelations, then the baselines.
	localparam int NUM_COUNTS = 2 * NUM_INPUTS + NUM_BASELINES;

	// header byte, two bytes per count, four bytes of tick count.
	localparam int FRAME_BYTES = 1 + 2 * NUM_COUNTS + 4;
	localparam logic [3:0] FRAME_HEADER = 4'hA;

	localparam int TICK_W = $clog2(TICK_CYCLES);
	localparam int BAUD_W = $clog2(BAUD_CYCLES);
	localparam int BYTE_W = $clog2(FRAME_BYTES);

	typedef logic [NUM_INPUTS-1:0] lines_t;
	typedef logic [RESOLUTION-1:0] count_t;
	typedef logic [31:0] ticks_t;
	typedef logic [NUM_COUNTS*RESOLUTION-1:0] counts_t;
	typedef logic [FRAME_BYTES*8-1:0] frame_t;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} tx_state_t;

endpackage

//--- corr_if.sv
// correlator internal buses
// sample stream and frame snapshot
`timescale 1ns/1ps

interface sample_if import corr_pkg::*; ();

	logic tick; // one pulse per sample period.
	lines_t bits;
	logic win_start;
	logic win_end;

	modport source (
		output tick,
		output bits,
		output win_start,
		output win_end
	);

	modport sink (
		input tick,
		input bits,
		input win_start,
		input win_end
	);

endinterface

interface frame_if import corr_pkg::*; ();

	logic frame_valid;
	counts_t counts; // count k sits at bits k*RESOLUTION upward.
	ticks_t ticks;
	lines_t overflow;

	modport source (
		output frame_valid,
		output counts,
		output ticks,
		output overflow
	);

	modport sink (
		input frame_valid,
		input counts,
		input ticks,
		input overflow
	);

endinterface

//--- line_sampler.sv
// detector line sampler
// synchronizers, tick generator and window edges
`timescale 1ns/1ps

module line_sampler import corr_pkg::*; (
	input  logic     intclk,
	input  logic     rst_n,
	input  lines_t   line_in,
	input  logic     strobe,
	input  lines_t   invert,
	sample_if.source smp
);

	lines_t line_s1;
	lines_t line_s2;
	logic strobe_s1;
	logic strobe_s2;
	logic strobe_d;
	logic [TICK_W-1:0] tick_cnt;

	// two flops on every asynchronous input.
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			line_s1 <= '0;
			line_s2 <= '0;
			strobe_s1 <= 1'b0;
			strobe_s2 <= 1'b0;
			strobe_d <= 1'b0;
		end else begin
			line_s1 <= line_in;
			line_s2 <= line_s1;
			strobe_s1 <= strobe;
			strobe_s2 <= strobe_s1;
			strobe_d <= strobe_s2;
		end
	end

	assign smp.bits = line_s2 ^ invert; // per-line polarity flip.

	// the edge pulses come one cycle after the synchronized strobe moves.
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			smp.win_start <= 1'b0;
			smp.win_end <= 1'b0;
		end else begin
			smp.win_start <= strobe_s2 & ~strobe_d;
			smp.win_end <= ~strobe_s2 & strobe_d;
		end
	end

	// free running sample tick.
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			smp.tick <= 1'b0;
		end else begin
			if (tick_cnt == TICK_W'(TICK_CYCLES - 1)) begin
				tick_cnt <= '0;
				smp.tick <= 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
				smp.tick <= 1'b0;
			end
		end
	end

endmodule

//--- corr_engine.sv
// one-bit correlation engine
// saturating counters and frame snapshot
`timescale 1ns/1ps

module corr_engine import corr_pkg::*; (
	input  logic    intclk,
	input  logic    rst_n,
	sample_if.sink  smp,
	frame_if.source frm
);

	logic win_open;
	logic first_tick; // no previous sample yet in this window.
	logic step;
	logic [NUM_COUNTS-1:0] inc;
	lines_t prev;
	lines_t ovf;
	ticks_t ticks;
	count_t cnt [NUM_COUNTS];

	// the tick that coincides with the closing edge is not counted.
	assign step = smp.tick & win_open & ~smp.win_end;

	always_comb begin
		int k;
		k = 2 * NUM_INPUTS;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			inc[i] = smp.bits[i];
			inc[NUM_INPUTS + i] = smp.bits[i] & prev[i] & ~first_tick;
		end
		// baselines in the order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3).
		for (int a = 0; a < NUM_INPUTS; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				inc[k] = smp.bits[a] & smp.bits[b];
				k++;
			end
		end
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			win_open <= 1'b0;
			first_tick <= 1'b0;
			frm.frame_valid <= 1'b0;
		end else begin
			frm.frame_valid <= smp.win_end & win_open; // lines up with the snapshot.
			if (smp.win_start) begin
				win_open <= 1'b1;
				first_tick <= 1'b1;
			end else if (smp.win_end) begin
				win_open <= 1'b0;
			end else if (step) begin
				first_tick <= 1'b0;
			end
		end
	end

	// counters are cleared at every window start.
	always_ff @(posedge intclk) begin
		if (smp.win_start) begin
			prev <= '0;
			ovf <= '0;
			ticks <= '0;
			for (int k = 0; k < NUM_COUNTS; k++) begin
				cnt[k] <= '0;
			end
		end else if (step) begin
			prev <= smp.bits;
			if (ticks != '1) begin
				ticks <= ticks + 1'b1;
			end
			for (int k = 0; k < NUM_COUNTS; k++) begin
				if (inc[k] && cnt[k] != '1) begin
					cnt[k] <= cnt[k] + 1'b1;
				end
			end
			// a total that is already at its maximum flags its line.
			for (int i = 0; i < NUM_INPUTS; i++) begin
				ovf[i] <= ovf[i] | (inc[i] & (cnt[i] == '1));
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (smp.win_end && win_open) begin
			for (int k = 0; k < NUM_COUNTS; k++) begin
				frm.counts[k*RESOLUTION +: RESOLUTION] <= cnt[k];
			end
			frm.ticks <= ticks;
			frm.overflow <= ovf;
		end
	end

endmodule

//--- frame_tx.sv
// frame transmitter
// bytes out as 8N1 UART
`timescale 1ns/1ps

module frame_tx import corr_pkg::*; (
	input  logic  intclk,
	input  logic  rst_n,
	frame_if.sink frm,
	output logic  tx,
	output logic  busy
);

	tx_state_t state;
	logic [BAUD_W-1:0] baud_cnt;
	logic [2:0] bit_idx;
	logic [BYTE_W-1:0] byte_idx;
	logic bit_end;
	frame_t frame_buf; // byte 0 in the low bits, shifted out LSB first.

	assign bit_end = (baud_cnt == BAUD_W'(BAUD_CYCLES - 1));
	assign busy = (state != IDLE);

	always_comb begin
		case (state)
			START: tx = 1'b0;
			DATA: tx = frame_buf[0];
			default: tx = 1'b1; // idle and stop are mark level.
		endcase
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			byte_idx <= '0;
		end else begin
			if (state == IDLE || bit_end) begin
				baud_cnt <= '0;
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end

			case (state)
				IDLE: begin
					if (frm.frame_valid) begin // frames arriving while busy are lost.
						state <= START;
						byte_idx <= '0;
					end
				end
				START: begin
					if (bit_end) begin
						state <= DATA;
						bit_idx <= '0;
					end
				end
				DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= STOP;
						end
					end
				end
				STOP: begin
					if (bit_end) begin
						if (byte_idx == BYTE_W'(FRAME_BYTES - 1)) begin
							state <= IDLE;
						end else begin
							byte_idx <= byte_idx + 1'b1;
							state <= START;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// header, then counts low byte first, then the tick count.
	always_ff @(posedge intclk) begin
		if (state == IDLE && frm.frame_valid) begin
			frame_buf <= {frm.ticks, frm.counts, FRAME_HEADER, frm.overflow};
		end else if (state == DATA && bit_end) begin
			frame_buf <= frame_buf >> 1;
		end
	end

endmodule

//--- correlator_top.sv
// one-bit correlator top level
// sampler, engine and UART transmitter
`timescale 1ns/1ps

module correlator_top import corr_pkg::*; (
	input  logic   intclk,
	input  logic   rst_n,
	input  lines_t line_in,
	input  lines_t invert,
	input  logic   strobe,
	output logic   tx,
	output logic   busy
);

	sample_if smp_bus ();
	frame_if frm_bus ();

	line_sampler u_sampler (
		.intclk  (intclk),
		.rst_n   (rst_n),
		.line_in (line_in),
		.strobe  (strobe),
		.invert  (invert),
		.smp     (smp_bus.source)
	);

	corr_engine u_engine (
		.intclk (intclk),
		.rst_n  (rst_n),
		.smp    (smp_bus.sink),
		.frm    (frm_bus.source)
	);

	// busy stays high for the whole frame.
	frame_tx u_tx (
		.intclk (intclk),
		.rst_n  (rst_n),
		.frm    (frm_bus.sink),
		.tx     (tx),
		.busy   (busy)
	);

endmodule

//--- tb_correlator.sv
// one-bit correlator testbench
// UART frame receiver and count model
`timescale 1ns/1ps

module tb_correlator import corr_pkg::*; ();

	localparam int START_TIMEOUT = 4000; // cycles to wait for a start bit.
	localparam int BUSY_TIMEOUT = 20 * BAUD_CYCLES;
	localparam int QUIET_CYCLES = 3000;
	localparam int SAT_CYCLES = 4 * 65600; // long enough to pass 65535 ticks.

	logic intclk;
	logic rst_n;
	lines_t line_in;
	lines_t invert;
	logic strobe;
	logic tx;
	logic busy;

	int checks = 0;
	int errors = 0;
	logic [7:0] rx_frame [FRAME_BYTES];

	correlator_top u_dut (
		.intclk  (intclk),
		.rst_n   (rst_n),
		.line_in (line_in),
		.invert  (invert),
		.strobe  (strobe),
		.tx      (tx),
		.busy    (busy)
	);

	initial begin
		intclk = 1'b0;
		forever #10 intclk = ~intclk;
	end

	task automatic abort_run(input string reason);
		errors++;
		$display("timeout: %s", reason);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("ERRORS FOUND");
		$finish;
	endtask

	function automatic void compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endfunction

	function automatic void check_idle();
		compare_value("tx", tx, 32'h1);
		compare_value("busy", busy, 32'h0);
	endfunction

	function automatic logic [15:0] saturate(input longint value);
		if (value > 65535) begin
			return 16'hFFFF;
		end
		return 16'(value);
	endfunction

	// count k arrives low byte first right after the header.
	function automatic logic [15:0] count_at(input int k);
		return {rx_frame[2*k+2], rx_frame[2*k+1]};
	endfunction

	// holds the pattern steady around a strobe pulse of high_cycles clocks.
	task automatic drive_window(input lines_t pattern, input lines_t mask,
			input int high_cycles, input bit idle_expected);
		@(posedge intclk);
		line_in <= pattern;
		invert <= mask;
		repeat (8) begin
			@(negedge intclk);
			if (idle_expected) begin
				check_idle();
			end
		end
		@(posedge intclk);
		strobe <= 1'b1;
		repeat (high_cycles) begin
			@(negedge intclk);
			if (idle_expected) begin
				check_idle();
			end
		end
		@(posedge intclk);
		strobe <= 1'b0;
	endtask

	task automatic receive_frame();
		int wait_cycles;
		logic [7:0] data;
		for (int b = 0; b < FRAME_BYTES; b++) begin
			wait_cycles = 0;
			do begin
				@(negedge intclk);
				wait_cycles++;
				if (wait_cycles > START_TIMEOUT) begin
					abort_run("no start bit arrived on tx");
				end
			end while (tx !== 1'b0);
			repeat (BAUD_CYCLES / 2) @(negedge intclk); // centre of the start bit.
			compare_value("tx start bit", tx, 32'h0);
			compare_value("busy", busy, 32'h1);
			for (int i = 0; i < 8; i++) begin
				repeat (BAUD_CYCLES) @(negedge intclk);
				data[i] = tx;
			end
			repeat (BAUD_CYCLES) @(negedge intclk);
			compare_value("tx stop bit", tx, 32'h1);
			rx_frame[b] = data;
		end
	endtask

	task automatic wait_not_busy();
		int wait_cycles;
		wait_cycles = 0;
		while (busy !== 1'b0) begin
			@(negedge intclk);
			wait_cycles++;
			if (wait_cycles > BUSY_TIMEOUT) begin
				abort_run("busy stayed high after the last stop bit");
			end
		end
	endtask

	// every result follows from the tick count n and the effective bits.
	task automatic check_frame(input lines_t eff, input int high_cycles);
		longint n;
		longint exp_n;
		lines_t exp_ovf;
		int k;
		n = {rx_frame[32], rx_frame[31], rx_frame[30], rx_frame[29]};
		exp_n = high_cycles / TICK_CYCLES;
		checks++;
		assert (n >= exp_n - 1 && n <= exp_n + 1) else begin
			errors++;
			$display("[FAIL] ticks: got %h, expected %h within one", n, exp_n);
		end
		for (int i = 0; i < NUM_INPUTS; i++) begin
			compare_value($sformatf("total[%0d]", i), count_at(i),
				saturate(eff[i] ? n : 0));
			compare_value($sformatf("auto[%0d]", i), count_at(NUM_INPUTS + i),
				saturate((eff[i] && n > 0) ? n - 1 : 0));
			exp_ovf[i] = eff[i] && (n > 65535);
		end
		k = 2 * NUM_INPUTS;
		for (int a = 0; a < NUM_INPUTS; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				compare_value($sformatf("cross[%0d%0d]", a, b), count_at(k),
					saturate((eff[a] && eff[b]) ? n : 0));
				k++;
			end
		end
		compare_value("header", rx_frame[0], {FRAME_HEADER, exp_ovf});
	endtask

	task automatic run_and_check(input lines_t pattern, input lines_t mask,
			input int high_cycles);
		drive_window(pattern, mask, high_cycles, 1'b1);
		receive_frame();
		wait_not_busy();
		check_frame(pattern ^ mask, high_cycles);
	endtask

	// the second window closes while the first frame is still on the line.
	task automatic check_dropped_frame();
		lines_t pattern_a;
		lines_t mask_a;
		pattern_a = $urandom % 16;
		mask_a = $urandom % 16;
		drive_window(pattern_a, mask_a, 120, 1'b1);
		fork
			receive_frame();
			begin
				repeat (40) @(negedge intclk);
				drive_window(~pattern_a, mask_a, 100, 1'b0);
			end
		join
		wait_not_busy();
		check_frame(pattern_a ^ mask_a, 120);
		repeat (QUIET_CYCLES) begin
			@(negedge intclk);
			check_idle(); // a second frame would pull tx low here.
		end
	endtask

	initial begin
		int unsigned seed_draw;
		lines_t pattern;
		lines_t mask;
		rst_n = 1'b0;
		strobe = 1'b0;
		line_in = '0;
		invert = '0;
		seed_draw = $urandom(32'h2412);
		repeat (3) @(posedge intclk);
		rst_n <= 1'b1;

		repeat (20) begin
			@(negedge intclk);
			check_idle();
		end

		repeat (4) begin
			pattern = $urandom % 16;
			mask = $urandom % 16;
			run_and_check(pattern, mask, 200);
		end

		// same lines, every polarity flipped.
		pattern = $urandom % 16;
		mask = $urandom % 16;
		run_and_check(pattern, mask, 160);
		run_and_check(pattern, ~mask, 160);

		run_and_check($urandom % 16, $urandom % 16, 37);
		run_and_check($urandom % 16, $urandom % 16, 413);
		run_and_check($urandom % 16, $urandom % 16, 90);

		run_and_check(4'hF, 4'h0, SAT_CYCLES);

		check_dropped_frame();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- files.f
corr_pkg.sv
corr_if.sv
line_sampler.sv
corr_engine.sv
frame_tx.sv
correlator_top.sv
tb_correlator.sv

//--- Bender.yml
package:
  name: correlator

sources:
  - corr_pkg.sv
  - corr_if.sv
  - line_sampler.sv
  - corr_engine.sv
  - frame_tx.sv
  - correlator_top.sv
  - target: simulation
    files:
      - tb_correlator.sv
